// ==== Bender.yml ====
package:
  name: sdram_ctrl

sources:
  - verilog/sdram_ctrl_pkg.sv
  - verilog/sdram_req_if.sv
  - verilog/sdram_cmd_if.sv
  - verilog/sdram_request_fifo.sv
  - verilog/sdram_refresh_timer.sv
  - verilog/sdram_init_seq.sv
  - verilog/sdram_cmd_seq.sv
  - verilog/sdram_read_capture.sv
  - verilog/sdram_ctrl.sv
  - target: test
    files:
      - testbench/sdram_ctrl_assert.sv
      - testbench/sdram_ctrl_checker.sv
      - testbench/sdram_ctrl_tb.sv

// ==== files.f ====
verilog/sdram_ctrl_pkg.sv
verilog/sdram_req_if.sv
verilog/sdram_cmd_if.sv
verilog/sdram_request_fifo.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_init_seq.sv
verilog/sdram_cmd_seq.sv
verilog/sdram_read_capture.sv
verilog/sdram_ctrl.sv
testbench/sdram_ctrl_assert.sv
testbench/sdram_ctrl_checker.sv
testbench/sdram_ctrl_tb.sv

// ==== testbench/sdram_ctrl_assert.sv ====
// bound assertions on read latency, dq enable and command order
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_assert
  import sdram_ctrl_pkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input sdram_cmd_e i_cmd,
  input logic       i_oe,
  input logic       i_rd_valid,
  input logic       i_init_done
);

  int fail_count;  // failed assertions so far

  initial
  begin
    fail_count = 0;
  end

  // valid rises cas latency plus the output flop after READ
  read_latency: assert property (@(posedge clk) disable iff (!reset_n)
    i_cmd == CMD_READ |-> ##(CAS_LATENCY + 1) $rose(i_rd_valid))
    else
    begin
      $error("read valid not aligned with READ");
      fail_count++;
    end

  oe_with_write: assert property (@(posedge clk) disable iff (!reset_n)
    i_oe |-> i_cmd == CMD_WRITE)
    else
    begin
      $error("dq driven outside WRITE");
      fail_count++;
    end

  access_after_init: assert property (@(posedge clk) disable iff (!reset_n)
    (i_cmd == CMD_READ || i_cmd == CMD_WRITE) |-> i_init_done)
    else
    begin
      $error("access before mode register load");
      fail_count++;
    end

endmodule

bind sdram_ctrl sdram_ctrl_assert assert_i (
  .clk (clk), .reset_n (reset_n), .i_cmd (cmd_if.cmd), .i_oe (cmd_if.oe),
  .i_rd_valid (o_rd_valid), .i_init_done (init_done)
);

`default_nettype wire

// ==== testbench/sdram_ctrl_checker.sv ====
// checker with shadow memory, read order, address map, init order and refresh spacing
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_checker
  import sdram_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset_n,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [BE_W-1:0]   i_be_n,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic i_rd_n,
  input  logic i_wr_n,
  input  logic i_waitrequest,
  input  logic i_rd_valid,
  input  logic [DATA_W-1:0] i_rd_data,
  input  sdram_cmd_e        i_cmd,
  input  logic [ROW_W-1:0]  i_sdram_addr,
  input  logic [BANK_W-1:0] i_sdram_ba,
  output int o_accepted,
  output int o_issued,
  output int o_valids,
  output int o_errors,
  output int o_refreshes
);

  localparam int REF_SLACK = 16;

  logic [DATA_W-1:0] shadow [bit [ADDR_W-1:0]];
  logic [DATA_W-1:0] exp_q [$];
  logic [ADDR_W-1:0] addr_q [$];
  logic [ADDR_W-1:0] cur;
  int phase, init_refs, cyc, last_ref;

  initial
  begin
    o_accepted  = 0;
    o_issued    = 0;
    o_valids    = 0;
    o_errors    = 0;
    o_refreshes = 0;
    phase       = 0;
    init_refs   = 0;
    cyc         = 0;
    last_ref    = -1;
  end

  task automatic fail(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    o_errors++;
  endtask

  always @(posedge clk)
  begin
    logic [DATA_W-1:0] v;
    if (reset_n)
    begin
      cyc++;
      if ((!i_rd_n || !i_wr_n) && !i_waitrequest)
      begin
        o_accepted++;
        v = shadow.exists(i_addr) ? shadow[i_addr] : '0;
        addr_q.push_back(i_addr);
        if (!i_rd_n)
          exp_q.push_back(v);
        else
        begin
          for (int i = 0; i < BE_W; i++)
            if (!i_be_n[i])
              v[8*i +: 8] = i_wdata[8*i +: 8];
          shadow[i_addr] = v;
        end
      end
      if (i_rd_valid)
      begin
        o_valids++;
        if (exp_q.size() == 0)
          fail("read valid with no read outstanding");
        else
        begin
          v = exp_q.pop_front();
          if (i_rd_data !== v)
            fail($sformatf("read data %h, expected %h", i_rd_data, v));
        end
      end
      // power-up order
      if (phase == 0 && i_cmd == CMD_PRECHARGE && i_sdram_addr == '1)
        phase = 1;
      else if (phase == 0 && i_cmd != CMD_INHIBIT && i_cmd != CMD_NOP)
        fail($sformatf("command %s before precharge all", i_cmd.name()));
      else if (phase == 1 && i_cmd == CMD_REFRESH)
        init_refs++;
      else if (phase == 1 && i_cmd == CMD_LOAD_MODE)
      begin
        if (i_sdram_addr != MODE_VALUE || init_refs != INIT_REFRESHES)
          fail($sformatf("load mode %h after %0d refreshes", i_sdram_addr, init_refs));
        phase = 2;
      end
      else if (phase == 2 && i_cmd == CMD_REFRESH)
      begin
        if (last_ref >= 0 && cyc - last_ref > REFRESH_PERIOD + 1 + REF_SLACK)
          fail($sformatf("refresh gap of %0d cycles", cyc - last_ref));
        last_ref = cyc;
        o_refreshes++;
      end
      if (phase < 2 && (i_cmd == CMD_ACTIVE || i_cmd == CMD_READ || i_cmd == CMD_WRITE))
        fail($sformatf("command %s before load mode", i_cmd.name()));
      if (last_ref >= 0 && cyc - last_ref == REFRESH_PERIOD + 2 + REF_SLACK)
        fail("no refresh within the allowed interval");
      // address map
      if (phase == 2 && i_cmd == CMD_ACTIVE)
      begin
        o_issued++;
        if (addr_q.size() == 0)
          fail("ACTIVE with no request accepted");
        else
          cur = addr_q.pop_front();
        if (i_sdram_ba != {cur[24], cur[10]} || i_sdram_addr != cur[23:11])
          fail($sformatf("ACTIVE bank %0d row %h for addr %h", i_sdram_ba, i_sdram_addr, cur));
      end
      if (phase == 2 && (i_cmd == CMD_READ || i_cmd == CMD_WRITE))
        if (i_sdram_ba != {cur[24], cur[10]} || i_sdram_addr[COL_W-1:0] != cur[9:0])
          fail($sformatf("column %h bank %0d for addr %h", i_sdram_addr, i_sdram_ba, cur));
    end
  end

endmodule

`default_nettype wire

// ==== testbench/sdram_ctrl_tb.sv ====
// testbench top with clock, reset, stimulus table, sdram model, timeout and summary
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_tb
  import sdram_ctrl_pkg::*;
();

  localparam int N_ENTRIES = 14;
  localparam int MAX_CYCLES = REFRESH_INIT + 40 * N_ENTRIES + 2000;

  typedef struct {
    bit              rnw;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be_n;
  } entry_t;

  logic clk;
  logic reset_n;
  logic [ADDR_W-1:0] addr;
  logic [BE_W-1:0]   be_n;
  logic [DATA_W-1:0] wdata;
  logic rd_n;
  logic wr_n;
  logic [DATA_W-1:0] rd_data;
  logic rd_valid;
  logic waitrequest;
  logic [ROW_W-1:0]  sd_addr;
  logic [BANK_W-1:0] sd_ba;
  logic cs_n, ras_n, cas_n, we_n;
  logic [BE_W-1:0]   sd_dqm;
  wire  [DATA_W-1:0] dq;

  entry_t      table_q [N_ENTRIES];
  logic [31:0] lfsr;
  int          cycles;
  int          n_reads;
  int          accepted, issued, valids, errors, refreshes;

  // sdram model state
  logic [DATA_W-1:0] mem [bit [ADDR_W-1:0]];
  logic [ROW_W-1:0]  open_row [4];
  logic [1:0]        rd_stage;
  logic [ADDR_W-1:0] rd_key [2];
  logic              drv_en;
  logic [DATA_W-1:0] drv_data;
  sdram_cmd_e        cmd;

  assign cmd = sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});
  assign dq  = drv_en ? drv_data : 'z;

  sdram_ctrl sdram_ctrl_i (
    .clk (clk), .reset_n (reset_n), .i_addr (addr), .i_be_n (be_n), .i_wdata (wdata),
    .i_rd_n (rd_n), .i_wr_n (wr_n), .o_rd_data (rd_data), .o_rd_valid (rd_valid),
    .o_waitrequest (waitrequest), .o_sdram_addr (sd_addr), .o_sdram_ba (sd_ba),
    .o_sdram_cs_n (cs_n), .o_sdram_ras_n (ras_n), .o_sdram_cas_n (cas_n),
    .o_sdram_we_n (we_n), .o_sdram_dqm (sd_dqm), .io_sdram_dq (dq)
  );

  sdram_ctrl_checker checker_i (
    .clk (clk), .reset_n (reset_n), .i_addr (addr), .i_be_n (be_n), .i_wdata (wdata),
    .i_rd_n (rd_n), .i_wr_n (wr_n), .i_waitrequest (waitrequest), .i_rd_valid (rd_valid),
    .i_rd_data (rd_data), .i_cmd (cmd), .i_sdram_addr (sd_addr), .i_sdram_ba (sd_ba),
    .o_accepted (accepted), .o_issued (issued), .o_valids (valids), .o_errors (errors),
    .o_refreshes (refreshes)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++)
    begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};  // one step per bit
    end
    return w;
  endfunction

  // sdram model with byte masked writes and cas 3 read drive
  always @(posedge clk)
  begin
    if (cmd == CMD_ACTIVE)
      open_row[sd_ba] <= sd_addr;
    if (cmd == CMD_WRITE)
    begin
      logic [ADDR_W-1:0] k;
      logic [DATA_W-1:0] v;
      k = {sd_ba, open_row[sd_ba], sd_addr[COL_W-1:0]};
      v = mem.exists(k) ? mem[k] : '0;
      for (int i = 0; i < BE_W; i++)
        if (!sd_dqm[i])
          v[8*i +: 8] = dq[8*i +: 8];
      mem[k] = v;
    end
    rd_stage  <= {rd_stage[0], cmd == CMD_READ};
    rd_key[0] <= {sd_ba, open_row[sd_ba], sd_addr[COL_W-1:0]};
    rd_key[1] <= rd_key[0];
    drv_en    <= rd_stage[1];
    drv_data  <= mem.exists(rd_key[1]) ? mem[rd_key[1]] : '0;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic set_entry(input int i, input bit rnw, input logic [ADDR_W-1:0] a,
                           input logic [BE_W-1:0] b);
    table_q[i].rnw  = rnw;
    table_q[i].addr = a;
    table_q[i].be_n = b;
  endtask

  initial
  begin
    cycles   = 0;
    lfsr     = 32'h3c29625d;
    rd_stage = '0;
    drv_en   = 1'b0;
    drv_data = '0;
    addr     = '0;
    be_n     = '1;
    wdata    = '0;
    rd_n     = 1'b1;
    wr_n     = 1'b1;
    reset_n  = 1'b0;
    set_entry(0,  0, 25'h000_0004, 4'b0000);
    set_entry(1,  0, 25'h100_0408, 4'b0000);  // bank 3
    set_entry(2,  1, 25'h000_0004, 4'b1111);
    set_entry(3,  0, 25'h000_0004, 4'b1010);  // partial write
    set_entry(4,  1, 25'h100_0408, 4'b1111);
    set_entry(5,  1, 25'h000_0004, 4'b1111);
    set_entry(6,  0, 25'h0ab_c3ff, 4'b0000);
    set_entry(7,  0, 25'h155_5555, 4'b0110);
    set_entry(8,  1, 25'h0ab_c3ff, 4'b1111);
    set_entry(9,  1, 25'h155_5555, 4'b1111);
    set_entry(10, 1, 25'h100_0408, 4'b1111);  // queued reads
    set_entry(11, 1, 25'h000_0800, 4'b1111);  // never written
    set_entry(12, 0, 25'h0ab_c3ff, 4'b1100);
    set_entry(13, 1, 25'h0ab_c3ff, 4'b1111);
    n_reads = 0;
    foreach (table_q[i])
      if (table_q[i].rnw)
        n_reads++;
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;
    for (int i = 0; i < N_ENTRIES; i++)
    begin
      addr  = table_q[i].addr;
      be_n  = table_q[i].be_n;
      wdata = table_q[i].rnw ? '0 : random_word();
      rd_n  = !table_q[i].rnw;
      wr_n  = table_q[i].rnw;
      do
        @(posedge clk);
      while (waitrequest);  // hold under back-pressure
      #1;
      $display("entry %0d %s addr %h accepted at %0t", i, table_q[i].rnw ? "read" : "write",
               table_q[i].addr, $time);
      rd_n = 1'b1;
      wr_n = 1'b1;
    end
    wait (valids >= n_reads && refreshes >= 2);
    repeat (10) @(posedge clk);
    $display("accepted %0d/%0d, issued %0d, valids %0d/%0d, refreshes %0d, errors %0d",
             accepted, N_ENTRIES, issued, valids, n_reads, refreshes,
             errors + sdram_ctrl_i.assert_i.fail_count);
    if (errors == 0 && sdram_ctrl_i.assert_i.fail_count == 0 && accepted == N_ENTRIES &&
        issued == N_ENTRIES && valids == n_reads)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/sdram_cmd_if.sv ====
// registered sdram pin command interface from sequencer to top level and read capture
`timescale 1ns/1ps
`default_nettype none

interface sdram_cmd_if
  import sdram_ctrl_pkg::*;
();

  sdram_cmd_e        cmd;
  logic [BANK_W-1:0] bank;
  logic [ROW_W-1:0]  addr;
  logic [BE_W-1:0]   dqm;
  logic [DATA_W-1:0] wdata;
  logic              oe;     // dq output enable

  // all driven from flops in the sequencer
  modport seq (output cmd, bank, addr, dqm, wdata, oe);

  modport pins (input cmd, bank, addr, dqm, wdata, oe);

endinterface

`default_nettype wire

// ==== verilog/sdram_cmd_seq.sv ====
// access and refresh command sequencer with registered pin outputs
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_seq
  import sdram_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  sdram_cmd_e       i_init_cmd,
  input  logic [ROW_W-1:0] i_init_addr,
  input  logic             i_init_done,
  input  logic             i_refresh_req,
  output logic             o_refresh_ack,
  sdram_req_if.seq         req,
  sdram_cmd_if.seq         pins
);

  seq_state_e           state_q;
  seq_state_e           next_q;
  logic [NOP_CNT_W-1:0] nop_cnt_q;
  logic                 start;

  // request held for the whole access
  logic                 rq_rnw;
  logic [ADDR_W-1:0]    rq_addr;
  logic [BE_W-1:0]      rq_dqm;
  logic [DATA_W-1:0]    rq_wdata;

  logic [BANK_W-1:0]    head_bank;
  logic [ROW_W-1:0]     head_row;
  logic [BANK_W-1:0]    rq_bank;
  logic [COL_W-1:0]     rq_col;

  assign head_bank = {req.addr[BANK_HI_BIT], req.addr[BANK_LO_BIT]};
  assign head_row  = req.addr[ROW_LSB +: ROW_W];
  assign rq_bank   = {rq_addr[BANK_HI_BIT], rq_addr[BANK_LO_BIT]};
  assign rq_col    = rq_addr[COL_LSB +: COL_W];

  // refresh wins over a waiting request
  assign start   = (state_q == SEQ_IDLE) && i_init_done && !i_refresh_req && req.valid;
  assign req.pop = start;

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      rq_rnw   <= req.rnw;
      rq_addr  <= req.addr;
      rq_dqm   <= req.dqm;
      rq_wdata <= req.wdata;
    end
    if (state_q == SEQ_ACCESS && !rq_rnw)
      pins.wdata <= rq_wdata;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q       <= SEQ_IDLE;
      next_q        <= SEQ_IDLE;
      nop_cnt_q     <= '0;
      o_refresh_ack <= 1'b0;
      pins.cmd      <= CMD_INHIBIT;
      pins.bank     <= '0;
      pins.addr     <= '0;
      pins.dqm      <= '0;
      pins.oe       <= 1'b0;
    end
    else
    begin
      o_refresh_ack <= 1'b0;
      pins.oe       <= 1'b0;
      pins.dqm      <= '0;
      case (state_q)
        SEQ_IDLE:
        begin
          if (!i_init_done)
          begin
            pins.cmd  <= i_init_cmd;  // init sequence owns the pins
            pins.addr <= i_init_addr;
          end
          else if (i_refresh_req)
          begin
            pins.cmd  <= CMD_PRECHARGE;
            pins.addr <= '1;          // all banks
            nop_cnt_q <= NOP_CNT_W'(T_RP_NOPS);
            next_q    <= SEQ_REFRESH;
            state_q   <= SEQ_GAP;
          end
          else if (start)
          begin
            pins.cmd  <= CMD_ACTIVE;
            pins.bank <= head_bank;
            pins.addr <= head_row;
            nop_cnt_q <= NOP_CNT_W'(T_RCD_NOPS);
            next_q    <= SEQ_ACCESS;
            state_q   <= SEQ_ACTIVATE;
          end
          else
            pins.cmd <= CMD_NOP;
        end
        SEQ_ACCESS:
        begin
          pins.cmd  <= rq_rnw ? CMD_READ : CMD_WRITE;
          pins.bank <= rq_bank;
          pins.addr <= ROW_W'(rq_col);  // A10 low, no auto precharge
          pins.dqm  <= rq_dqm;
          pins.oe   <= !rq_rnw;
          nop_cnt_q <= NOP_CNT_W'(T_WR_NOPS);
          next_q    <= SEQ_PRECHARGE;
          state_q   <= SEQ_GAP;
        end
        SEQ_PRECHARGE:
        begin
          pins.cmd  <= CMD_PRECHARGE;
          pins.addr <= '0;  // close only the open bank
          nop_cnt_q <= NOP_CNT_W'(T_RP_NOPS);
          next_q    <= SEQ_IDLE;
          state_q   <= SEQ_GAP;
        end
        SEQ_REFRESH:
        begin
          pins.cmd      <= CMD_REFRESH;
          o_refresh_ack <= 1'b1;
          nop_cnt_q     <= NOP_CNT_W'(T_RFC_NOPS);
          next_q        <= SEQ_IDLE;
          state_q       <= SEQ_GAP;
        end
        SEQ_ACTIVATE, SEQ_GAP:
        begin
          pins.cmd <= CMD_NOP;
          if (nop_cnt_q > 1)
            nop_cnt_q <= nop_cnt_q - 1'b1;
          else
            state_q <= next_q;
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sdram_ctrl.sv ====
// sdram controller top level with request port, pin split and dq tri-state
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl
  import sdram_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [BE_W-1:0]   i_be_n,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic              i_rd_n,
  input  logic              i_wr_n,
  output logic [DATA_W-1:0] o_rd_data,
  output logic              o_rd_valid,
  output logic              o_waitrequest,
  output logic [ROW_W-1:0]  o_sdram_addr,
  output logic [BANK_W-1:0] o_sdram_ba,
  output logic              o_sdram_cs_n,
  output logic              o_sdram_ras_n,
  output logic              o_sdram_cas_n,
  output logic              o_sdram_we_n,
  output logic [BE_W-1:0]   o_sdram_dqm,
  inout  wire  [DATA_W-1:0] io_sdram_dq
);

  sdram_req_if req_if ();
  sdram_cmd_if cmd_if ();

  logic             fifo_wr;
  logic             tick;
  logic             refresh_req;
  logic             refresh_ack;
  sdram_cmd_e       init_cmd;
  logic [ROW_W-1:0] init_addr;
  logic             init_done;

  // either strobe queues a request unless the fifo is full
  assign fifo_wr = (!i_wr_n || !i_rd_n) && !o_waitrequest;

  sdram_request_fifo request_fifo_i (
    .clk     (clk),
    .reset_n (reset_n),
    .i_wr    (fifo_wr),
    .i_rnw   (i_wr_n),
    .i_addr  (i_addr),
    .i_dqm   (i_be_n),
    .i_wdata (i_wdata),
    .o_full  (o_waitrequest),
    .req     (req_if.fifo)
  );

  sdram_refresh_timer refresh_timer_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_init_done   (init_done),
    .i_refresh_ack (refresh_ack),
    .o_tick        (tick),
    .o_refresh_req (refresh_req)
  );

  sdram_init_seq init_seq_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_tick      (tick),
    .o_init_cmd  (init_cmd),
    .o_init_addr (init_addr),
    .o_init_done (init_done)
  );

  sdram_cmd_seq cmd_seq_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_init_cmd    (init_cmd),
    .i_init_addr   (init_addr),
    .i_init_done   (init_done),
    .i_refresh_req (refresh_req),
    .o_refresh_ack (refresh_ack),
    .req           (req_if.seq),
    .pins          (cmd_if.seq)
  );

  sdram_read_capture read_capture_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_dq       (io_sdram_dq),
    .pins       (cmd_if.pins),
    .o_rd_data  (o_rd_data),
    .o_rd_valid (o_rd_valid)
  );

  assign {o_sdram_cs_n, o_sdram_ras_n, o_sdram_cas_n, o_sdram_we_n} = cmd_if.cmd;
  assign o_sdram_addr = cmd_if.addr;
  assign o_sdram_ba   = cmd_if.bank;
  assign o_sdram_dqm  = cmd_if.dqm;
  assign io_sdram_dq  = cmd_if.oe ? cmd_if.wdata : 'z;  // driven only during WRITE

endmodule

`default_nettype wire

// ==== verilog/sdram_ctrl_pkg.sv ====
// widths, timing constants, address map and command/state enums for the sdram controller
`default_nettype none

package sdram_ctrl_pkg;

  // request and device widths
  localparam int ADDR_W = 25;
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;
  localparam int ROW_W  = 13;
  localparam int BANK_W = 2;
  localparam int COL_W  = 10;

  // bank is split around the row field
  localparam int ROW_LSB     = 11;
  localparam int BANK_HI_BIT = 24;
  localparam int BANK_LO_BIT = 10;
  localparam int COL_LSB     = 0;

  // refresh timing in clock cycles
  localparam int REFRESH_INIT   = 5000;  // power-up wait
  localparam int REFRESH_PERIOD = 781;
  localparam int REFRESH_CNT_W  = $clog2(REFRESH_INIT + 1);

  localparam int CAS_LATENCY    = 3;
  localparam int T_RCD_NOPS     = 1;
  localparam int T_WR_NOPS      = 1;
  localparam int T_RP_NOPS      = 1;
  localparam int T_RFC_NOPS     = 3;
  localparam int T_MRD_NOPS     = 2;
  localparam int NOP_CNT_W      = 3;
  localparam int INIT_REFRESHES = 2;
  localparam int INIT_REF_W     = $clog2(INIT_REFRESHES + 1);

  // cas latency 3, burst length 1, sequential
  localparam logic [ROW_W-1:0] MODE_VALUE = 13'h030;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVE    = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_NOP       = 4'b0111,
    CMD_INHIBIT   = 4'b1111
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    INIT_WAIT_COUNT, INIT_PRECHARGE, INIT_REFRESH, INIT_LOAD_MODE, INIT_GAP, INIT_DONE
  } init_state_e;

  typedef enum logic [2:0] {
    SEQ_IDLE, SEQ_ACTIVATE, SEQ_ACCESS, SEQ_PRECHARGE, SEQ_REFRESH, SEQ_GAP
  } seq_state_e;

endpackage

`default_nettype wire

// ==== verilog/sdram_init_seq.sv ====
// power-up command sequence and init done flag
`timescale 1ns/1ps
`default_nettype none

module sdram_init_seq
  import sdram_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  logic             i_tick,
  output sdram_cmd_e       o_init_cmd,
  output logic [ROW_W-1:0] o_init_addr,
  output logic             o_init_done
);

  init_state_e           state_q;
  init_state_e           next_q;   // where to go after the gap
  logic [NOP_CNT_W-1:0]  gap_q;
  logic [INIT_REF_W-1:0] refs_q;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q     <= INIT_WAIT_COUNT;
      next_q      <= INIT_WAIT_COUNT;
      gap_q       <= '0;
      refs_q      <= '0;
      o_init_cmd  <= CMD_INHIBIT;
      o_init_addr <= '1;
      o_init_done <= 1'b0;
    end
    else
    begin
      o_init_addr <= '1;  // A10 high for precharge all
      case (state_q)
        INIT_WAIT_COUNT:
        begin
          o_init_cmd <= CMD_INHIBIT;
          refs_q     <= '0;
          if (i_tick)
            state_q <= INIT_PRECHARGE;
        end
        INIT_PRECHARGE:
        begin
          o_init_cmd <= CMD_PRECHARGE;
          gap_q      <= NOP_CNT_W'(T_RP_NOPS);
          next_q     <= INIT_REFRESH;
          state_q    <= INIT_GAP;
        end
        INIT_REFRESH:
        begin
          o_init_cmd <= CMD_REFRESH;
          refs_q     <= refs_q + 1'b1;
          gap_q      <= NOP_CNT_W'(T_RFC_NOPS);
          if (refs_q == INIT_REF_W'(INIT_REFRESHES - 1))
            next_q <= INIT_LOAD_MODE;
          else
            next_q <= INIT_REFRESH;
          state_q <= INIT_GAP;
        end
        INIT_LOAD_MODE:
        begin
          o_init_cmd  <= CMD_LOAD_MODE;
          o_init_addr <= MODE_VALUE;
          gap_q       <= NOP_CNT_W'(T_MRD_NOPS);
          next_q      <= INIT_DONE;
          state_q     <= INIT_GAP;
        end
        INIT_GAP:
        begin
          o_init_cmd <= CMD_NOP;
          if (gap_q > 1)
            gap_q <= gap_q - 1'b1;
          else
            state_q <= next_q;
        end
        INIT_DONE:
        begin
          o_init_cmd  <= CMD_NOP;
          o_init_done <= 1'b1;  // sticky until reset
        end
        default: state_q <= INIT_WAIT_COUNT;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sdram_read_capture.sv ====
// cas latency read valid pipeline and dq input register
`timescale 1ns/1ps
`default_nettype none

module sdram_read_capture
  import sdram_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic [DATA_W-1:0] i_dq,
  sdram_cmd_if.pins         pins,
  output logic [DATA_W-1:0] o_rd_data,
  output logic              o_rd_valid
);

  logic [CAS_LATENCY-1:0] rd_pipe;  // one stage per latency cycle

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_pipe    <= '0;
      o_rd_valid <= 1'b0;
    end
    else
    begin
      rd_pipe    <= {rd_pipe[CAS_LATENCY-2:0], pins.cmd == CMD_READ};
      o_rd_valid <= rd_pipe[CAS_LATENCY-1];  // lines up with o_rd_data
    end
  end

  always_ff @(posedge clk)
  begin
    o_rd_data <= i_dq;
  end

endmodule

`default_nettype wire

// ==== verilog/sdram_refresh_timer.sv ====
// refresh countdown timer and latched refresh request
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_timer
  import sdram_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset_n,
  input  logic i_init_done,
  input  logic i_refresh_ack,
  output logic o_tick,
  output logic o_refresh_req
);

  logic [REFRESH_CNT_W-1:0] count_q;

  assign o_tick = (count_q == '0);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      count_q       <= REFRESH_CNT_W'(REFRESH_INIT);  // first tick starts init
      o_refresh_req <= 1'b0;
    end
    else
    begin
      if (o_tick)
        count_q <= REFRESH_CNT_W'(REFRESH_PERIOD);
      else
        count_q <= count_q - 1'b1;
      // held until the sequencer acknowledges
      o_refresh_req <= (o_tick || o_refresh_req) && !i_refresh_ack && i_init_done;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sdram_req_if.sv ====
// queued request interface between request fifo and command sequencer
`timescale 1ns/1ps
`default_nettype none

interface sdram_req_if
  import sdram_ctrl_pkg::*;
();

  logic              valid;  // fifo not empty
  logic              rnw;
  logic [ADDR_W-1:0] addr;
  logic [BE_W-1:0]   dqm;
  logic [DATA_W-1:0] wdata;
  logic              pop;    // head advances at this edge

  modport fifo (output valid, rnw, addr, dqm, wdata, input pop);

  modport seq (input valid, rnw, addr, dqm, wdata, output pop);

endinterface

`default_nettype wire

// ==== verilog/sdram_request_fifo.sv ====
// two-entry request fifo with full and empty tracking
`timescale 1ns/1ps
`default_nettype none

module sdram_request_fifo
  import sdram_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              i_wr,
  input  logic              i_rnw,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [BE_W-1:0]   i_dqm,
  input  logic [DATA_W-1:0] i_wdata,
  output logic              o_full,
  sdram_req_if.fifo         req
);

  logic              rnw_mem   [2];
  logic [ADDR_W-1:0] addr_mem  [2];
  logic [BE_W-1:0]   dqm_mem   [2];
  logic [DATA_W-1:0] wdata_mem [2];
  logic              wr_ptr;  // one bit wraps over two entries
  logic              rd_ptr;
  logic [1:0]        count_q;
  logic              push;
  logic              pull;

  assign o_full    = (count_q == 2'd2);
  assign req.valid = (count_q != 2'd0);
  assign push      = i_wr && !o_full;
  assign pull      = req.pop && req.valid;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      count_q <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr <= !wr_ptr;
      if (pull)
        rd_ptr <= !rd_ptr;
      case ({push, pull})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      rnw_mem[wr_ptr]   <= i_rnw;
      addr_mem[wr_ptr]  <= i_addr;
      dqm_mem[wr_ptr]   <= i_rnw ? '0 : i_dqm;  // reads never mask
      wdata_mem[wr_ptr] <= i_wdata;
    end
  end

  // head entry
  assign req.rnw   = rnw_mem[rd_ptr];
  assign req.addr  = addr_mem[rd_ptr];
  assign req.dqm   = dqm_mem[rd_ptr];
  assign req.wdata = wdata_mem[rd_ptr];

endmodule

`default_nettype wire
